// File: lights_defines.svh
`ifndef LIGHTS_DEFINES_SVH
`define LIGHTS_DEFINES_SVH

// grid geometry with one word per row
`define LIGHTS_GRID_ROWS 16
`define LIGHTS_ROW_BITS 5
`define LIGHTS_GRID_COLS 32

`define LIGHTS_FIFO_DEPTH 4

// host register map
`define LIGHTS_ADDR_WIDTH 12
`define LIGHTS_ADDR_STATUS 12'h000
`define LIGHTS_ADDR_COUNT 12'h004
`define LIGHTS_ADDR_ROW_BASE 12'h100

`define LIGHTS_BYTE_WIDTH 8

`endif

// File: lights_pkg.sv
`include "lights_defines.svh"

package lights_pkg;

    typedef enum logic [1:0] {
        turn_off = 2'b00,
        toggle   = 2'b01,
        turn_on  = 2'b11
    } op_t;

    typedef logic [11:0] position_t;  // decimal coordinate from the text

    typedef struct packed {
        logic      last;              // final line of the program
        op_t       op;
        position_t start_row;
        position_t start_col;
        position_t end_row;
        position_t end_col;
    } instr_t;

    typedef logic [`LIGHTS_GRID_COLS-1:0] row_word_t;

    typedef logic [9:0] lit_count_t;

    typedef enum logic [1:0] {
        okay   = 2'b00,
        slverr = 2'b10
    } axi_resp_t;

endpackage

// File: line_decoder.sv
`timescale 1ns/1ps
`include "lights_defines.svh"

module line_decoder import lights_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          byte_valid,
    input  logic [`LIGHTS_BYTE_WIDTH-1:0] byte_data,
    output logic                          instr_valid,
    output instr_t                        instr_data,
    output logic                          end_of_file
);

    typedef logic [`LIGHTS_BYTE_WIDTH-1:0] char_t;

    localparam char_t nul_char   = 8'h00;
    localparam char_t lf_char    = 8'h0A;
    localparam char_t space_char = 8'h20;
    localparam char_t comma_char = 8'h2C;
    localparam char_t zero_char  = 8'h30;
    localparam char_t nine_char  = 8'h39;
    localparam char_t f_char     = 8'h66;
    localparam char_t n_char     = 8'h6E;
    localparam char_t o_char     = 8'h6F;
    localparam char_t t_char     = 8'h74;

    typedef enum logic [1:0] {
        cap_start_row,
        cap_start_col,
        cap_end_row,
        cap_end_col
    } cap_state_t;

    cap_state_t state, state_next;
    char_t      prev_char;
    op_t        op;
    logic       last_flag;
    position_t  position;
    position_t  start_row, start_col, end_row, end_col;

    function automatic logic is_digit(char_t c);
        return (c >= zero_char) && (c <= nine_char);
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_char <= nul_char;
            op        <= turn_off;
            state     <= cap_start_row;
        end else begin
            state <= state_next;
            if (byte_valid) begin
                prev_char <= byte_data;
                // operation is named by a two-letter pair
                if ({prev_char, byte_data} == {o_char, f_char}) op <= turn_off;
                if ({prev_char, byte_data} == {t_char, o_char}) op <= toggle;
                if ({prev_char, byte_data} == {o_char, n_char}) op <= turn_on;
            end
        end
    end

    // separators walk the four coordinates
    always_comb begin
        state_next = state;
        unique case (state)
            cap_start_row: if (byte_valid && byte_data == comma_char) state_next = cap_start_col;
            cap_start_col: if (byte_valid && byte_data == space_char) state_next = cap_end_row;
            cap_end_row:   if (byte_valid && byte_data == comma_char) state_next = cap_end_col;
            cap_end_col:   if (instr_valid) state_next = cap_start_row;
            default:       state_next = cap_start_row;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            position <= '0;
        end else if (byte_valid && is_digit(byte_data)) begin
            if (is_digit(prev_char)) begin
                position <= 10 * position + position_t'(byte_data - zero_char);
            end else begin
                position <= position_t'(byte_data - zero_char);  // first digit
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            start_row <= '0;
            start_col <= '0;
            end_row   <= '0;
            end_col   <= '0;
        end else if (byte_valid) begin
            unique case (state)
                cap_start_row: start_row <= position;
                cap_start_col: start_col <= position;
                cap_end_row:   end_row   <= position;
                default:       end_col   <= position;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instr_valid <= 1'b0;
            last_flag   <= 1'b0;
            end_of_file <= 1'b0;
        end else begin
            instr_valid <= byte_valid && (prev_char == lf_char);
            if (byte_valid && prev_char == lf_char) begin
                last_flag <= (byte_data == nul_char);  // nul right after the line feed
            end
            if (byte_valid && prev_char == nul_char && byte_data == nul_char) begin
                end_of_file <= 1'b1;
            end
        end
    end

    assign instr_data = {last_flag, op, start_row, start_col, end_row, end_col};

endmodule

// File: instr_fifo.sv
`timescale 1ns/1ps
`include "lights_defines.svh"

module instr_fifo import lights_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   push,
    input  instr_t push_data,
    output logic   fifo_valid,
    output instr_t fifo_data,
    input  logic   pop,
    output logic   byte_ready
);

    localparam int depth    = `LIGHTS_FIFO_DEPTH;
    localparam int ptr_bits = $clog2(depth);

    typedef logic [ptr_bits:0] count_t;

    instr_t              buffer [depth];
    logic [ptr_bits-1:0] rd_ptr, wr_ptr;
    count_t              count, count_next;
    logic                do_push, do_pop;

    assign do_pop     = pop && fifo_valid;
    assign do_push    = push && (count != count_t'(depth) || do_pop);
    assign count_next = count + count_t'(do_push) - count_t'(do_pop);
    assign fifo_valid = (count != '0);
    assign fifo_data  = buffer[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            count      <= '0;
            byte_ready <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            count      <= count_next;
            byte_ready <= (count_next <= count_t'(depth - 2));  // room for one more line
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) buffer[wr_ptr] <= push_data;
    end

endmodule

// File: grid_updater.sv
`timescale 1ns/1ps
`include "lights_defines.svh"

module grid_updater import lights_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        fifo_valid,
    input  instr_t                      fifo_data,
    output logic                        pop,
    output logic                        mem_req,
    output logic                        mem_we,
    output logic [`LIGHTS_ROW_BITS-1:0] mem_addr,
    output row_word_t                   mem_wdata,
    input  logic                        mem_grant,
    input  row_word_t                   mem_rdata,
    input  logic                        mem_rdata_valid,
    output lit_count_t                  lit_count,
    output logic                        clear_done,
    output logic                        done
);

    localparam int row_bits = `LIGHTS_ROW_BITS;
    localparam int col_bits = $clog2(`LIGHTS_GRID_COLS);

    typedef enum logic [2:0] {
        st_clear,
        st_idle,
        st_read,
        st_wait,
        st_write
    } upd_state_t;

    upd_state_t          state;
    logic [row_bits-1:0] row;
    row_word_t           mask, modified, new_word;
    logic                at_end_row;

    function automatic row_word_t apply_op(op_t op, row_word_t word, row_word_t sel);
        unique case (op)
            turn_on:  return word | sel;
            turn_off: return word & ~sel;
            default:  return word ^ sel;
        endcase
    endfunction

    // head of the FIFO stays put until the pop, so it serves as the current instruction
    assign mask = (row_word_t'('1) << fifo_data.start_col[col_bits-1:0])
                & (row_word_t'('1) >> (col_bits'(`LIGHTS_GRID_COLS - 1)
                                       - fifo_data.end_col[col_bits-1:0]));
    assign modified   = apply_op(fifo_data.op, mem_rdata, mask);
    assign at_end_row = (row == fifo_data.end_row[row_bits-1:0]);

    assign mem_req   = (state == st_clear) || (state == st_read) || (state == st_write);
    assign mem_we    = (state == st_clear) || (state == st_write);
    assign mem_addr  = row;
    assign mem_wdata = (state == st_clear) ? '0 : new_word;
    assign pop       = (state == st_write) && mem_grant && at_end_row;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_clear;
            row        <= '0;
            lit_count  <= '0;
            clear_done <= 1'b0;
            done       <= 1'b0;
        end else begin
            unique case (state)
                st_clear: if (mem_grant) begin
                    if (row == row_bits'(`LIGHTS_GRID_ROWS - 1)) begin
                        clear_done <= 1'b1;
                        state      <= st_idle;
                    end else begin
                        row <= row + 1'b1;
                    end
                end
                st_idle: if (fifo_valid) begin
                    row   <= fifo_data.start_row[row_bits-1:0];
                    state <= st_read;
                end
                st_read: if (mem_grant) state <= st_wait;
                st_wait: if (mem_rdata_valid) begin
                    // net change in lit bits for this row
                    lit_count <= lit_count + lit_count_t'($countones(modified))
                                           - lit_count_t'($countones(mem_rdata));
                    state     <= st_write;
                end
                st_write: if (mem_grant) begin
                    if (at_end_row) begin
                        done  <= done | fifo_data.last;
                        state <= st_idle;
                    end else begin
                        row   <= row + 1'b1;
                        state <= st_read;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_wait && mem_rdata_valid) new_word <= modified;
    end

endmodule

// File: grid_store.sv
`timescale 1ns/1ps
`include "lights_defines.svh"

module grid_store import lights_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        upd_req,
    input  logic                        upd_we,
    input  logic [`LIGHTS_ROW_BITS-1:0] upd_addr,
    input  row_word_t                   upd_wdata,
    output logic                        upd_grant,
    output row_word_t                   upd_rdata,
    output logic                        upd_rdata_valid,
    input  logic                        host_req,
    input  logic                        host_we,
    input  logic [`LIGHTS_ROW_BITS-1:0] host_addr,
    input  row_word_t                   host_wdata,
    output logic                        host_grant,
    output row_word_t                   host_rdata,
    output logic                        host_rdata_valid
);

    localparam int idx_bits = $clog2(`LIGHTS_GRID_ROWS);

    row_word_t                   grid [`LIGHTS_GRID_ROWS];
    row_word_t                   rdata_q;
    logic                        host_first;  // round-robin pointer
    logic                        sel_we;
    logic [`LIGHTS_ROW_BITS-1:0] sel_addr;
    row_word_t                   sel_wdata;

    assign host_grant = host_req && (host_first || !upd_req);
    assign upd_grant  = upd_req && !host_grant;

    assign sel_we    = host_grant ? host_we : upd_we;
    assign sel_addr  = host_grant ? host_addr : upd_addr;
    assign sel_wdata = host_grant ? host_wdata : upd_wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            host_first       <= 1'b0;
            upd_rdata_valid  <= 1'b0;
            host_rdata_valid <= 1'b0;
        end else begin
            if (host_grant || upd_grant) host_first <= upd_grant;  // loser goes first next
            upd_rdata_valid  <= upd_grant && !upd_we;
            host_rdata_valid <= host_grant && !host_we;
        end
    end

    always_ff @(posedge clk) begin
        if ((host_grant || upd_grant) && sel_we) grid[sel_addr[idx_bits-1:0]] <= sel_wdata;
        rdata_q <= grid[sel_addr[idx_bits-1:0]];
    end

    // single read port whose valid flags tell the owner
    assign upd_rdata  = rdata_q;
    assign host_rdata = rdata_q;

endmodule

// File: axil_grid_port.sv
`timescale 1ns/1ps
`include "lights_defines.svh"

module axil_grid_port import lights_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic                          wvalid,
    output logic                          wready,
    output logic                          bvalid,
    input  logic                          bready,
    output axi_resp_t                     bresp,
    input  logic                          arvalid,
    output logic                          arready,
    input  logic [`LIGHTS_ADDR_WIDTH-1:0] araddr,
    output logic                          rvalid,
    input  logic                          rready,
    output logic [31:0]                   rdata,
    output axi_resp_t                     rresp,
    input  lit_count_t                    lit_count,
    input  logic                          clear_done,
    input  logic                          done,
    output logic                          mem_req,
    output logic                          mem_we,
    output logic [`LIGHTS_ROW_BITS-1:0]   mem_addr,
    output row_word_t                     mem_wdata,
    input  logic                          mem_grant,
    input  row_word_t                     mem_rdata,
    input  logic                          mem_rdata_valid
);

    typedef enum logic [2:0] {
        ap_idle,
        ap_ar,
        ap_aw,
        ap_mem_req,
        ap_mem_wait,
        ap_rresp,
        ap_bresp
    } port_state_t;

    port_state_t                 state;
    logic [`LIGHTS_ROW_BITS-1:0] row_addr;
    logic                        is_row;
    logic [31:0]                 direct_data;
    axi_resp_t                   direct_resp;

    always_comb begin
        is_row = (araddr >= `LIGHTS_ADDR_ROW_BASE)
              && (araddr < `LIGHTS_ADDR_ROW_BASE + 4 * `LIGHTS_GRID_ROWS)
              && (araddr[1:0] == 2'b00);
        direct_data = '0;
        direct_resp = slverr;  // unmapped unless matched below
        if (araddr == `LIGHTS_ADDR_STATUS) begin
            direct_data = {30'b0, clear_done, done};
            direct_resp = okay;
        end else if (araddr == `LIGHTS_ADDR_COUNT) begin
            direct_data = 32'(lit_count);
            direct_resp = okay;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ap_idle;
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            rvalid  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            unique case (state)
                ap_idle: if (arvalid) begin
                    arready <= 1'b1;
                    state   <= ap_ar;
                end else if (awvalid && wvalid) begin
                    awready <= 1'b1;
                    wready  <= 1'b1;
                    state   <= ap_aw;
                end
                ap_ar: begin  // address taken this cycle
                    arready <= 1'b0;
                    if (is_row) begin
                        state <= ap_mem_req;
                    end else begin
                        rvalid <= 1'b1;
                        state  <= ap_rresp;
                    end
                end
                ap_aw: begin
                    awready <= 1'b0;
                    wready  <= 1'b0;
                    bvalid  <= 1'b1;
                    state   <= ap_bresp;
                end
                ap_mem_req: if (mem_grant) state <= ap_mem_wait;
                ap_mem_wait: if (mem_rdata_valid) begin
                    rvalid <= 1'b1;
                    state  <= ap_rresp;
                end
                ap_rresp: if (rready) begin
                    rvalid <= 1'b0;
                    state  <= ap_idle;
                end
                ap_bresp: if (bready) begin
                    bvalid <= 1'b0;
                    state  <= ap_idle;
                end
                default: state <= ap_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ap_ar) begin
            rdata    <= direct_data;
            rresp    <= direct_resp;
            row_addr <= `LIGHTS_ROW_BITS'((araddr - `LIGHTS_ADDR_ROW_BASE) >> 2);
        end else if (state == ap_mem_wait && mem_rdata_valid) begin
            rdata <= mem_rdata;
            rresp <= okay;
        end
    end

    assign bresp     = slverr;  // grid is read-only from the host
    assign mem_req   = (state == ap_mem_req);
    assign mem_we    = 1'b0;
    assign mem_addr  = row_addr;
    assign mem_wdata = '0;

endmodule

// File: lights_top.sv
`timescale 1ns/1ps
`include "lights_defines.svh"

module lights_top import lights_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          byte_valid,
    input  logic [`LIGHTS_BYTE_WIDTH-1:0] byte_data,
    output logic                          byte_ready,
    output logic                          end_of_file,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic                          wvalid,
    output logic                          wready,
    output logic                          bvalid,
    input  logic                          bready,
    output axi_resp_t                     bresp,
    input  logic                          arvalid,
    output logic                          arready,
    input  logic [`LIGHTS_ADDR_WIDTH-1:0] araddr,
    output logic                          rvalid,
    input  logic                          rready,
    output logic [31:0]                   rdata,
    output axi_resp_t                     rresp
);

    logic                        instr_valid;
    instr_t                      instr_data;
    logic                        fifo_valid, pop;
    instr_t                      fifo_data;
    logic                        upd_req, upd_we, upd_grant, upd_rdata_valid;
    logic [`LIGHTS_ROW_BITS-1:0] upd_addr;
    row_word_t                   upd_wdata, upd_rdata;
    logic                        host_req, host_we, host_grant, host_rdata_valid;
    logic [`LIGHTS_ROW_BITS-1:0] host_addr;
    row_word_t                   host_wdata, host_rdata;
    lit_count_t                  lit_count;
    logic                        clear_done, done;

    line_decoder line_decoder_inst (
        .clk, .reset, .byte_valid, .byte_data, .instr_valid, .instr_data, .end_of_file
    );

    instr_fifo instr_fifo_inst (
        .clk, .reset, .push(instr_valid), .push_data(instr_data),
        .fifo_valid, .fifo_data, .pop, .byte_ready
    );

    grid_updater grid_updater_inst (
        .clk, .reset, .fifo_valid, .fifo_data, .pop,
        .mem_req(upd_req), .mem_we(upd_we), .mem_addr(upd_addr), .mem_wdata(upd_wdata),
        .mem_grant(upd_grant), .mem_rdata(upd_rdata), .mem_rdata_valid(upd_rdata_valid),
        .lit_count, .clear_done, .done
    );

    grid_store grid_store_inst (
        .clk, .reset,
        .upd_req, .upd_we, .upd_addr, .upd_wdata, .upd_grant, .upd_rdata, .upd_rdata_valid,
        .host_req, .host_we, .host_addr, .host_wdata, .host_grant, .host_rdata,
        .host_rdata_valid
    );

    axil_grid_port axil_grid_port_inst (
        .clk, .reset,
        .awvalid, .awready, .wvalid, .wready, .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
        .lit_count, .clear_done, .done,
        .mem_req(host_req), .mem_we(host_we), .mem_addr(host_addr), .mem_wdata(host_wdata),
        .mem_grant(host_grant), .mem_rdata(host_rdata), .mem_rdata_valid(host_rdata_valid)
    );

endmodule

// File: lights_tb.sv
`timescale 1ns/1ps
`include "lights_defines.svh"

module lights_tb import lights_pkg::*; ();

    localparam int num_entries = 12;
    localparam int num_fixed   = 8;
    localparam int max_cycles  = 200 * num_entries + 2000;
    localparam int rows        = `LIGHTS_GRID_ROWS;
    localparam int cols        = `LIGHTS_GRID_COLS;

    // one rectangle of the program given by its row and col corners
    typedef struct packed {
        op_t        op;
        logic [4:0] r0;
        logic [4:0] c0;
        logic [4:0] r1;
        logic [4:0] c1;
    } rect_t;

    logic                          clk;
    logic                          reset;
    logic                          byte_valid;
    logic [`LIGHTS_BYTE_WIDTH-1:0] byte_data;
    logic                          byte_ready;
    logic                          end_of_file;
    logic                          awvalid, awready, wvalid, wready;
    logic                          bvalid, bready;
    axi_resp_t                     bresp;
    logic                          arvalid, arready;
    logic [`LIGHTS_ADDR_WIDTH-1:0] araddr;
    logic                          rvalid, rready;
    logic [31:0]                   rdata;
    axi_resp_t                     rresp;

    rect_t     rects [num_entries];
    row_word_t ref_grid [rows];
    int        seed;
    int        cycle_count = 0;

    lights_top lights_top_inst (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == max_cycles) begin
            $display("Error: the design never finished within %0d cycles", max_cycles);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_row(string name, row_word_t expected, row_word_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, got %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_count(string name, lit_count_t expected, lit_count_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, got %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_resp(string name, axi_resp_t expected, axi_resp_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, got %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, got %h", name, expected, actual);
            abort_run();
        end
    endtask

    function automatic rect_t make_rect(op_t op, int r0, int c0, int r1, int c1);
        return {op, 5'(r0), 5'(c0), 5'(r1), 5'(c1)};
    endfunction

    function automatic string op_text(op_t op);
        case (op)
            turn_on:  return "turn on";
            turn_off: return "turn off";
            default:  return "toggle";
        endcase
    endfunction

    task automatic build_table();
        int   e, a, b, c, d;
        op_t  op;
        rects[0] = make_rect(turn_on, 0, 0, 9, 3);
        rects[1] = make_rect(toggle, 2, 5, 4, 30);
        rects[2] = make_rect(turn_off, 1, 1, 1, 1);
        rects[3] = make_rect(toggle, 0, 0, 15, 31);   // whole grid
        rects[4] = make_rect(turn_off, 6, 8, 11, 23);
        rects[5] = make_rect(turn_on, 13, 0, 15, 31);
        rects[6] = make_rect(toggle, 3, 16, 14, 16);
        rects[7] = make_rect(turn_on, 10, 12, 10, 12);
        for (e = num_fixed; e < num_entries; e++) begin
            a = {$random(seed)} % rows;
            b = {$random(seed)} % rows;
            c = {$random(seed)} % cols;
            d = {$random(seed)} % cols;
            case ({$random(seed)} % 3)
                0:       op = turn_off;
                1:       op = toggle;
                default: op = turn_on;
            endcase
            // corners sorted so start is at or below end
            rects[e] = make_rect(op, (a < b) ? a : b, (c < d) ? c : d,
                                 (a < b) ? b : a, (c < d) ? d : c);
        end
    endtask

    task automatic apply_reference();
        int e, r, c;
        for (r = 0; r < rows; r++) ref_grid[r] = '0;
        for (e = 0; e < num_entries; e++) begin
            for (r = int'(rects[e].r0); r <= int'(rects[e].r1); r++) begin
                for (c = int'(rects[e].c0); c <= int'(rects[e].c1); c++) begin
                    case (rects[e].op)
                        turn_on:  ref_grid[r][c] = 1'b1;
                        turn_off: ref_grid[r][c] = 1'b0;
                        default:  ref_grid[r][c] = ~ref_grid[r][c];
                    endcase
                end
            end
        end
    endtask

    function automatic lit_count_t count_reference();
        int total, r, c;
        total = 0;
        for (r = 0; r < rows; r++) begin
            for (c = 0; c < cols; c++) total += int'(ref_grid[r][c]);
        end
        return lit_count_t'(total);
    endfunction

    task automatic send_byte(logic [7:0] value);
        int gap;
        while (!byte_ready) @(negedge clk);  // source stalls on back-pressure
        byte_valid = 1'b1;
        byte_data  = value;
        @(negedge clk);
        byte_valid = 1'b0;
        gap = 1 + ({$random(seed)} % 3);
        repeat (gap) @(negedge clk);
    endtask

    task automatic send_program();
        string line;
        int    e, i;
        for (e = 0; e < num_entries; e++) begin
            line = $sformatf("%s %0d,%0d through %0d,%0d\n", op_text(rects[e].op),
                             rects[e].r0, rects[e].c0, rects[e].r1, rects[e].c1);
            for (i = 0; i < line.len(); i++) send_byte(line[i]);
        end
        send_byte(8'h00);
        send_byte(8'h00);
    endtask

    task automatic read_reg(logic [11:0] addr, int stall, output logic [31:0] data,
                            output axi_resp_t resp);
        arvalid = 1'b1;
        araddr  = addr;
        do @(negedge clk); while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        repeat (stall) @(negedge clk);  // rready held low
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic write_reg(output axi_resp_t resp);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(negedge clk); while (!(awready && wready));
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        resp = bresp;
        repeat (2) @(negedge clk);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic poll_status(int bit_index);
        logic [31:0] data;
        axi_resp_t   resp;
        data = '0;
        while (!data[bit_index]) begin
            read_reg(`LIGHTS_ADDR_STATUS, 0, data, resp);
            check_resp("rresp", okay, resp);
        end
    endtask

    // host activity while the program is running
    task automatic host_traffic();
        logic [31:0] data;
        axi_resp_t   resp;
        int          k;
        for (k = 0; k < 4; k++) begin
            repeat (30) @(negedge clk);
            read_reg(12'(`LIGHTS_ADDR_ROW_BASE + 4 * ((5 * k) % rows)), 3 + k, data, resp);
            check_resp("rresp", okay, resp);
        end
        read_reg(12'h008, 2, data, resp);  // unmapped
        check_resp("rresp", slverr, resp);
        check_row("rdata", '0, data);
        write_reg(resp);
        check_resp("bresp", slverr, resp);
    endtask

    initial begin
        logic [31:0] data;
        axi_resp_t   resp;
        int          r;
        clk        = 1'b0;
        reset      = 1'b1;
        byte_valid = 1'b0;
        byte_data  = '0;
        awvalid    = 1'b0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        seed       = 32'h4b36;
        build_table();
        apply_reference();
        repeat (3) @(negedge clk);
        check_flag("byte_ready", 1'b0, byte_ready);
        reset = 1'b0;

        // grid must come out of the clear sweep empty
        poll_status(1);
        read_reg(`LIGHTS_ADDR_STATUS, 0, data, resp);
        check_flag("done", 1'b0, data[0]);
        for (r = 0; r < rows; r++) begin
            read_reg(12'(`LIGHTS_ADDR_ROW_BASE + 4 * r), 0, data, resp);
            check_resp("rresp", okay, resp);
            check_row($sformatf("row[%0d]", r), '0, data);
        end
        read_reg(`LIGHTS_ADDR_COUNT, 0, data, resp);
        check_count("lit_count", '0, lit_count_t'(data));
        check_flag("byte_ready", 1'b1, byte_ready);
        check_flag("end_of_file", 1'b0, end_of_file);

        fork
            send_program();
            host_traffic();
        join

        poll_status(0);
        check_flag("end_of_file", 1'b1, end_of_file);
        for (r = 0; r < rows; r++) begin
            read_reg(12'(`LIGHTS_ADDR_ROW_BASE + 4 * r), 1, data, resp);
            check_resp("rresp", okay, resp);
            check_row($sformatf("row[%0d]", r), ref_grid[r], data);
        end
        read_reg(`LIGHTS_ADDR_COUNT, 0, data, resp);
        check_resp("rresp", okay, resp);
        check_count("lit_count", count_reference(), lit_count_t'(data));

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
lights_pkg.sv
line_decoder.sv
instr_fifo.sv
grid_updater.sv
grid_store.sv
axil_grid_port.sv
lights_top.sv
lights_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the lights testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log
( verilator --binary --timing -Wno-fatal --top-module lights_tb -f flist.f \
    && ./obj_dir/Vlights_tb ) > sim.log 2>&1

grep -q "^Test completed successfully$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
